/* source/wb_pkg.sv */
package wb_pkg;

    // --------------------------------------------------
    // Widths and plain vector types

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;       // Data word
    typedef logic [4:0]      reg_addr_t;   // GPR index
    typedef logic [4:0]      fu_t;         // One-hot functional unit
    typedef logic [4:0]      uop_t;        // Micro-op code
    typedef logic [11:0]     csr_addr_t;
    typedef logic [5:0]      trap_cause_t;
    typedef logic [1:0]      isize_t;      // Instruction size in halfwords

    // --------------------------------------------------
    // Functional unit bits of fu_t

    localparam int P_FU_ALU = 0;
    localparam int P_FU_MUL = 1;
    localparam int P_FU_LSU = 2;
    localparam int P_FU_CFU = 3;
    localparam int P_FU_CSR = 4;

    // CSR micro-op bits
    localparam int CSR_READ  = 0;
    localparam int CSR_WRITE = 1;
    localparam int CSR_SET   = 2;
    localparam int CSR_CLEAR = 3;

    // LSU micro-op bits and size field in uop[2:1]
    localparam int LSU_SIGNED = 0;
    localparam int LSU_LOAD   = 3;
    localparam int LSU_STORE  = 4;

    localparam logic [1:0] LSU_BYTE = 2'd1;
    localparam logic [1:0] LSU_HALF = 2'd2;
    localparam logic [1:0] LSU_WORD = 2'd3;

    // CFU micro-ops
    localparam uop_t CFU_JALI   = 5'd1;
    localparam uop_t CFU_JALR   = 5'd2;
    localparam uop_t CFU_LINK   = 5'd3;    // Link write only
    localparam uop_t CFU_MRET   = 5'd4;
    localparam uop_t CFU_EBREAK = 5'd5;
    localparam uop_t CFU_ECALL  = 5'd6;
    localparam uop_t CFU_PT_C   = 5'd7;    // Predicted taken, correct
    localparam uop_t CFU_PT_W   = 5'd8;    // Predicted taken, wrong
    localparam uop_t CFU_PNT_C  = 5'd9;    // Predicted not taken, correct
    localparam uop_t CFU_PNT_W  = 5'd10;   // Predicted not taken, wrong

    // --------------------------------------------------
    // Trap causes and reset PC

    localparam trap_cause_t TRAP_BREAKPT  = 6'd3;
    localparam trap_cause_t TRAP_LDACCESS = 6'd5;
    localparam trap_cause_t TRAP_STACCESS = 6'd7;
    localparam trap_cause_t TRAP_ECALLM   = 6'd11;

    localparam xlen_t PC_RESET = 32'h8000_0000;

    // Side effect finished while the pipeline is still stalled
    typedef enum logic {
        PH_WORK,
        PH_DONE
    } wb_phase_t;

endpackage

/* source/wb_ctrl.sv */
`timescale 1ns/1ps

module wb_ctrl (
    input  logic              g_clk,
    input  logic              g_resetn,
    input  logic              s4_valid,
    input  wb_pkg::fu_t       s4_fu,
    input  wb_pkg::uop_t      s4_uop,
    input  wb_pkg::isize_t    s4_size,
    input  wb_pkg::xlen_t     s4_opr_a,
    input  wb_pkg::xlen_t     s4_opr_b,
    input  logic              cf_need,      // Resolver wants a control-flow change
    input  wb_pkg::xlen_t     cf_next_pc,
    input  logic              cf_ack,
    input  logic              dmem_recv,
    input  logic              dmem_error,
    output logic              phase_done,
    output wb_pkg::xlen_t     pc,
    output wb_pkg::xlen_t     pc_next_seq,
    output logic              progress,
    output logic              s4_busy,
    output logic              cf_req,
    output logic              dmem_ack,
    output logic              hold_lsu_req,
    output logic              lsu_err,
    output logic              lsu_wen,
    output logic              csr_rd_wen,
    output logic              csr_en,
    output logic              csr_wr,
    output logic              csr_wr_set,
    output logic              csr_wr_clr,
    output wb_pkg::csr_addr_t csr_addr,
    output wb_pkg::xlen_t     csr_wdata,
    output logic              trs_valid
);
    import wb_pkg::*;

    wb_phase_t phase;
    wb_phase_t phase_nxt;
    logic      err_q;       // Bus error taken, trap still to be requested
    logic      fu_lsu;
    logic      fu_csr;
    logic      rsp_take;    // Memory response consumed this cycle
    logic      side_done;

    assign fu_lsu     = s4_valid && s4_fu[P_FU_LSU];
    assign fu_csr     = s4_valid && s4_fu[P_FU_CSR];
    assign phase_done = (phase == PH_DONE);

    // --------------------------------------------------
    // Handshakes and stall

    // Request held until acked, then dropped by PH_DONE
    assign cf_req = s4_valid && cf_need && !phase_done;

    // Expect a response until one is taken
    assign dmem_ack = fu_lsu && !phase_done && !err_q;
    assign rsp_take = dmem_ack && dmem_recv;

    // Error turns into a trap request
    assign lsu_err = (rsp_take && dmem_error) || err_q;
    assign lsu_wen = rsp_take && !dmem_error && s4_uop[LSU_LOAD];   // Load data valid

    assign s4_busy      = cf_req || (dmem_ack && !dmem_recv);
    assign progress     = s4_valid && !s4_busy;
    assign hold_lsu_req = cf_req || dmem_ack;   // No new LSU request yet

    // --------------------------------------------------
    // CSR strobe, one cycle per instruction

    // No CSR access from a trapping instruction
    assign csr_en     = fu_csr && !cf_need && !phase_done;
    assign csr_wr     = csr_en && s4_uop[CSR_WRITE];
    assign csr_wr_set = csr_en && s4_uop[CSR_SET];
    assign csr_wr_clr = csr_en && s4_uop[CSR_CLEAR];
    assign csr_addr   = s4_opr_b[11:0];
    assign csr_wdata  = s4_opr_a;
    assign csr_rd_wen = csr_en && s4_uop[CSR_READ];     // Read value to rd

    // --------------------------------------------------
    // Phase state

    assign side_done = (cf_req && cf_ack) || csr_en;

    always_comb begin
        phase_nxt = phase;
        if (progress) begin
            phase_nxt = PH_WORK;                        // Next instruction
        end else if (side_done) begin
            phase_nxt = PH_DONE;
        end
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            phase <= PH_WORK;
            err_q <= 1'b0;
        end else begin
            phase <= phase_nxt;
            if (progress) begin
                err_q <= 1'b0;
            end else if (rsp_take && dmem_error) begin
                err_q <= 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Program counter

    assign pc_next_seq = pc + xlen_t'({s4_size, 1'b0});

    // PC keeps the instruction's own address until retire
    // so trace, trap PC and link data stay right while acked
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc <= PC_RESET;
        end else if (progress) begin
            pc <= cf_next_pc;
        end
    end

    assign trs_valid = progress && (s4_size != '0);    // Zero size is a bubble

endmodule

/* source/wb_cf_resolve.sv */
`timescale 1ns/1ps

module wb_cf_resolve (
    input  wb_pkg::fu_t         s4_fu,
    input  wb_pkg::uop_t        s4_uop,
    input  logic                s4_trap,
    input  wb_pkg::xlen_t       s4_opr_a,
    input  wb_pkg::xlen_t       pc_next_seq,
    input  logic                lsu_err,
    input  wb_pkg::xlen_t       csr_mepc,
    input  wb_pkg::xlen_t       csr_mtvec,
    input  logic                progress,
    output logic                cf_need,
    output wb_pkg::xlen_t       cf_target,
    output wb_pkg::xlen_t       cf_next_pc,
    output logic                link_wen,
    output logic                trap_cpu,
    output wb_pkg::trap_cause_t trap_cause,
    output logic                exec_mret
);
    import wb_pkg::*;

    logic fu_cfu;
    logic cfu_jali;
    logic cfu_jalr;
    logic cfu_link;
    logic cfu_mret;
    logic cfu_ebreak;
    logic cfu_ecall;
    logic pred_wrong;   // Branch went the other way
    logic tgt_opra;     // Destination carried in operand A
    logic tgt_npc;      // Destination is the fall-through PC
    logic lsu_load;
    logic lsu_store;

    // --------------------------------------------------
    // Micro-op decode

    assign fu_cfu     = s4_fu[P_FU_CFU];
    assign cfu_jali   = fu_cfu && (s4_uop == CFU_JALI);
    assign cfu_jalr   = fu_cfu && (s4_uop == CFU_JALR);
    assign cfu_link   = fu_cfu && (s4_uop == CFU_LINK);
    assign cfu_mret   = fu_cfu && (s4_uop == CFU_MRET);
    assign cfu_ebreak = fu_cfu && (s4_uop == CFU_EBREAK);
    assign cfu_ecall  = fu_cfu && (s4_uop == CFU_ECALL);

    assign pred_wrong = fu_cfu && (s4_uop == CFU_PT_W || s4_uop == CFU_PNT_W);

    assign tgt_opra = cfu_jali || cfu_jalr || cfu_link ||
                      (fu_cfu && (s4_uop == CFU_PT_C || s4_uop == CFU_PNT_W));
    assign tgt_npc  = fu_cfu && (s4_uop == CFU_PT_W || s4_uop == CFU_PNT_C);

    assign lsu_load  = s4_fu[P_FU_LSU] && s4_uop[LSU_LOAD];
    assign lsu_store = s4_fu[P_FU_LSU] && s4_uop[LSU_STORE];

    // --------------------------------------------------
    // Request and target

    assign trap_cpu = cfu_ebreak || cfu_ecall || s4_trap || lsu_err;

    // LINK and correct predictions need no redirect
    assign cf_need = pred_wrong || cfu_jalr || cfu_mret || trap_cpu;

    always_comb begin
        if (trap_cpu) begin
            cf_target = csr_mtvec;                      // Any trap to the handler
        end else if (cfu_mret) begin
            cf_target = csr_mepc;
        end else if (tgt_npc) begin
            cf_target = pc_next_seq;
        end else begin
            cf_target = s4_opr_a;
        end
    end

    // PC after retire
    always_comb begin
        if (cf_need) begin
            cf_next_pc = cf_target;
        end else if (tgt_opra) begin
            cf_next_pc = s4_opr_a;
        end else begin
            cf_next_pc = pc_next_seq;
        end
    end

    assign link_wen = cfu_jali || cfu_jalr || cfu_link;

    // --------------------------------------------------
    // Trap cause in priority order

    always_comb begin
        if (lsu_err && lsu_load) begin
            trap_cause = TRAP_LDACCESS;
        end else if (lsu_err && lsu_store) begin
            trap_cause = TRAP_STACCESS;
        end else if (cfu_ebreak) begin
            trap_cause = TRAP_BREAKPT;
        end else if (cfu_ecall) begin
            trap_cause = TRAP_ECALLM;
        end else begin
            trap_cause = s4_opr_a[5:0];                 // Earlier stage cause
        end
    end

    assign exec_mret = cfu_mret && progress;            // One pulse at retire

endmodule

/* source/wb_load_align.sv */
`timescale 1ns/1ps

module wb_load_align (
    input  wb_pkg::uop_t  s4_uop,
    input  wb_pkg::xlen_t s4_opr_a,     // Byte strobes in [3:0]
    input  wb_pkg::xlen_t s4_opr_b,     // Access address
    input  wb_pkg::xlen_t dmem_rdata,
    output wb_pkg::xlen_t load_data
);
    import wb_pkg::*;

    logic [3:0]  strb;
    logic [1:0]  addr;
    logic        ld_byte;
    logic        ld_half;
    logic        ld_word;
    logic        ld_signed;
    logic [7:0]  byte0;
    logic [7:0]  byte1;
    logic [15:0] upper;

    assign strb      = s4_opr_a[3:0];
    assign addr      = s4_opr_b[1:0];
    assign ld_byte   = (s4_uop[2:1] == LSU_BYTE);
    assign ld_half   = (s4_uop[2:1] == LSU_HALF);
    assign ld_word   = (s4_uop[2:1] == LSU_WORD);
    assign ld_signed = s4_uop[LSU_SIGNED];

    // --------------------------------------------------
    // Byte lanes into place

    // Low byte from the addressed lane
    assign byte0 = {8{strb[0]}}                    & dmem_rdata[7:0]   |
                   {8{ld_byte && addr == 2'b01}}   & dmem_rdata[15:8]  |
                   {8{ld_byte && addr == 2'b10}}   & dmem_rdata[23:16] |
                   {8{ld_half && addr[1]}}         & dmem_rdata[23:16] |
                   {8{ld_byte && addr == 2'b11}}   & dmem_rdata[31:24];

    // Second byte or sign of a byte load
    assign byte1 = {8{ld_byte && ld_signed}}       & {8{byte0[7]}}     |
                   {8{ld_half && !addr[1]}}        & dmem_rdata[15:8]  |
                   {8{ld_half && addr[1]}}         & dmem_rdata[31:24] |
                   {8{ld_word}}                    & dmem_rdata[15:8];

    // Upper half is the sign or the word
    assign upper = {16{(ld_byte || ld_half) && ld_signed}} & {16{byte1[7]}} |
                   {16{ld_word}}                           & dmem_rdata[31:16];

    assign load_data = {upper, byte1, byte0};

endmodule

/* source/wb_gpr_select.sv */
`timescale 1ns/1ps

module wb_gpr_select (
    input  wb_pkg::fu_t       s4_fu,
    input  logic              s4_trap,
    input  wb_pkg::xlen_t     s4_opr_a,
    input  logic              csr_rd_wen,
    input  logic              lsu_wen,
    input  logic              link_wen,
    input  wb_pkg::xlen_t     csr_rdata,
    input  wb_pkg::xlen_t     load_data,
    input  wb_pkg::xlen_t     pc_next_seq,
    input  wb_pkg::reg_addr_t s4_rd,
    output logic              gpr_wen,
    output wb_pkg::reg_addr_t gpr_rd,
    output wb_pkg::xlen_t     gpr_wdata
);
    import wb_pkg::*;

    logic ex_wen;   // ALU or MUL result in operand A

    assign ex_wen = s4_fu[P_FU_ALU] || s4_fu[P_FU_MUL];

    // --------------------------------------------------
    // Write enable and data

    // Trapping instruction leaves rd untouched
    assign gpr_wen = !s4_trap && (ex_wen || csr_rd_wen || lsu_wen || link_wen);

    assign gpr_rd = s4_rd;

    // One source active per instruction
    assign gpr_wdata = {XLEN{ex_wen}}     & s4_opr_a    |
                       {XLEN{csr_rd_wen}} & csr_rdata   |
                       {XLEN{lsu_wen}}    & load_data   |
                       {XLEN{link_wen}}   & pc_next_seq;    // Return address

endmodule

/* source/frv_writeback.sv */
`timescale 1ns/1ps

module frv_writeback (
    input  logic                g_clk,
    input  logic                g_resetn,
    input  logic                s4_valid,
    input  wb_pkg::reg_addr_t   s4_rd,
    input  wb_pkg::xlen_t       s4_opr_a,
    input  wb_pkg::xlen_t       s4_opr_b,
    input  wb_pkg::uop_t        s4_uop,
    input  wb_pkg::fu_t         s4_fu,
    input  logic                s4_trap,
    input  wb_pkg::isize_t      s4_size,
    input  logic [31:0]         s4_instr,
    output logic                s4_busy,
    output logic                cf_req,
    output wb_pkg::xlen_t       cf_target,
    input  logic                cf_ack,
    input  logic                dmem_recv,
    output logic                dmem_ack,
    input  wb_pkg::xlen_t       dmem_rdata,
    input  logic                dmem_error,
    output logic                csr_en,
    output logic                csr_wr,
    output logic                csr_wr_set,
    output logic                csr_wr_clr,
    output wb_pkg::csr_addr_t   csr_addr,
    output wb_pkg::xlen_t       csr_wdata,
    input  wb_pkg::xlen_t       csr_rdata,
    output logic                gpr_wen,
    output wb_pkg::reg_addr_t   gpr_rd,
    output wb_pkg::xlen_t       gpr_wdata,
    output wb_pkg::reg_addr_t   fwd_s4_rd,
    output wb_pkg::xlen_t       fwd_s4_wdata,
    output logic                fwd_s4_load,
    output logic                fwd_s4_csr,
    output logic                trap_cpu,
    output wb_pkg::trap_cause_t trap_cause,
    output wb_pkg::xlen_t       trap_pc,
    output logic                exec_mret,
    input  wb_pkg::xlen_t       csr_mepc,
    input  wb_pkg::xlen_t       csr_mtvec,
    output logic                hold_lsu_req,
    output wb_pkg::xlen_t       trs_pc,
    output logic [31:0]         trs_instr,
    output logic                trs_valid
);
    import wb_pkg::*;

    logic  phase_done;
    xlen_t pc;
    xlen_t pc_next_seq;
    logic  progress;
    logic  lsu_err;
    logic  lsu_wen;
    logic  csr_rd_wen;
    logic  cf_need;
    xlen_t cf_next_pc;
    logic  link_wen;
    logic  link_wr;     // Link write only while the jump is pending
    xlen_t load_data;
    fu_t   fu_vld;      // Unit field of a valid instruction
    logic  trap_vld;

    assign fu_vld   = s4_fu & {$bits(fu_t){s4_valid}};
    assign trap_vld = s4_valid && s4_trap;
    assign link_wr  = link_wen && !phase_done;

    // --------------------------------------------------
    // Submodules

    wb_ctrl u_wb_ctrl (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .s4_valid    (s4_valid),
        .s4_fu       (s4_fu),
        .s4_uop      (s4_uop),
        .s4_size     (s4_size),
        .s4_opr_a    (s4_opr_a),
        .s4_opr_b    (s4_opr_b),
        .cf_need     (cf_need),
        .cf_next_pc  (cf_next_pc),
        .cf_ack      (cf_ack),
        .dmem_recv   (dmem_recv),
        .dmem_error  (dmem_error),
        .phase_done  (phase_done),
        .pc          (pc),
        .pc_next_seq (pc_next_seq),
        .progress    (progress),
        .s4_busy     (s4_busy),
        .cf_req      (cf_req),
        .dmem_ack    (dmem_ack),
        .hold_lsu_req(hold_lsu_req),
        .lsu_err     (lsu_err),
        .lsu_wen     (lsu_wen),
        .csr_rd_wen  (csr_rd_wen),
        .csr_en      (csr_en),
        .csr_wr      (csr_wr),
        .csr_wr_set  (csr_wr_set),
        .csr_wr_clr  (csr_wr_clr),
        .csr_addr    (csr_addr),
        .csr_wdata   (csr_wdata),
        .trs_valid   (trs_valid)
    );

    wb_cf_resolve u_wb_cf_resolve (
        .s4_fu       (fu_vld),
        .s4_uop      (s4_uop),
        .s4_trap     (trap_vld),
        .s4_opr_a    (s4_opr_a),
        .pc_next_seq (pc_next_seq),
        .lsu_err     (lsu_err),
        .csr_mepc    (csr_mepc),
        .csr_mtvec   (csr_mtvec),
        .progress    (progress),
        .cf_need     (cf_need),
        .cf_target   (cf_target),
        .cf_next_pc  (cf_next_pc),
        .link_wen    (link_wen),
        .trap_cpu    (trap_cpu),
        .trap_cause  (trap_cause),
        .exec_mret   (exec_mret)
    );

    wb_load_align u_wb_load_align (
        .s4_uop      (s4_uop),
        .s4_opr_a    (s4_opr_a),
        .s4_opr_b    (s4_opr_b),
        .dmem_rdata  (dmem_rdata),
        .load_data   (load_data)
    );

    wb_gpr_select u_wb_gpr_select (
        .s4_fu       (fu_vld),
        .s4_trap     (trap_vld),
        .s4_opr_a    (s4_opr_a),
        .csr_rd_wen  (csr_rd_wen),
        .lsu_wen     (lsu_wen),
        .link_wen    (link_wr),
        .csr_rdata   (csr_rdata),
        .load_data   (load_data),
        .pc_next_seq (pc_next_seq),
        .s4_rd       (s4_rd),
        .gpr_wen     (gpr_wen),
        .gpr_rd      (gpr_rd),
        .gpr_wdata   (gpr_wdata)
    );

    // --------------------------------------------------
    // Forwarding, trap PC and trace

    assign fwd_s4_rd    = gpr_rd;
    assign fwd_s4_wdata = gpr_wdata;
    assign fwd_s4_load  = fu_vld[P_FU_LSU] && s4_uop[LSU_LOAD];     // Data may be late
    assign fwd_s4_csr   = fu_vld[P_FU_CSR];

    assign trap_pc   = pc;
    assign trs_pc    = pc;
    assign trs_instr = s4_instr;

endmodule

/* verification/tb_writeback_ref.svh */
`ifndef TB_WRITEBACK_REF_SVH
`define TB_WRITEBACK_REF_SVH

// --------------------------------------------------
// Random source and small helpers

// Plain 32-bit LCG step
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// One-hot unit field from a bit position
function automatic fu_t fu_onehot(input int pos);
    fu_t f;
    f = '0;
    f[pos] = 1'b1;
    return f;
endfunction

// --------------------------------------------------
// Expected results

// Loaded word as seen in rd, shifted down by the byte address
function automatic xlen_t ref_load(input logic [1:0] size, input logic sgn,
                                   input logic [1:0] addr, input xlen_t rdata);
    xlen_t sh;
    sh = rdata >> {addr, 3'b000};
    case (size)
        LSU_BYTE: return sgn ? {{24{sh[7]}}, sh[7:0]} : {24'h0, sh[7:0]};
        LSU_HALF: return sgn ? {{16{sh[15]}}, sh[15:0]} : {16'h0, sh[15:0]};
        default:  return rdata;                 // Word as is
    endcase
endfunction

// Redirect wanted for wrong predictions, JALR and the trap-like ops
function automatic logic ref_cf_need(input uop_t op);
    return op == CFU_PT_W || op == CFU_PNT_W || op == CFU_JALR ||
           op == CFU_MRET || op == CFU_ECALL || op == CFU_EBREAK;
endfunction

// Destination of a CFU op, also its next PC
function automatic xlen_t ref_cf_target(input uop_t op, input xlen_t opa, input xlen_t seq,
                                        input xlen_t mepc, input xlen_t mtvec);
    if (op == CFU_ECALL || op == CFU_EBREAK) return mtvec;
    if (op == CFU_MRET) return mepc;
    if (op == CFU_PT_W || op == CFU_PNT_C) return seq;  // Fall through
    return opa;
endfunction

function automatic logic ref_link(input uop_t op);
    return op == CFU_JALI || op == CFU_JALR || op == CFU_LINK;
endfunction

function automatic trap_cause_t ref_trap_cause(input uop_t op);
    return (op == CFU_EBREAK) ? TRAP_BREAKPT : TRAP_ECALLM;
endfunction

`endif

/* verification/tb_writeback.sv */
`timescale 1ns/1ps

module tb_writeback;
    import wb_pkg::*;

    `include "tb_writeback_ref.svh"

    localparam int NUM_TESTS = 33;
    localparam int MAX_CYCLES = 64 * NUM_TESTS;

    logic g_clk;
    logic g_resetn;
    logic s4_valid, s4_trap, s4_busy, cf_req, cf_ack, dmem_recv, dmem_ack, dmem_error;
    reg_addr_t s4_rd, gpr_rd, fwd_s4_rd;
    xlen_t s4_opr_a, s4_opr_b, cf_target, dmem_rdata, csr_wdata, csr_rdata, gpr_wdata;
    xlen_t fwd_s4_wdata, trap_pc, csr_mepc, csr_mtvec, trs_pc;
    uop_t s4_uop;
    fu_t s4_fu;
    isize_t s4_size;
    logic [31:0] s4_instr, trs_instr;
    logic csr_en, csr_wr, csr_wr_set, csr_wr_clr, gpr_wen, fwd_s4_load, fwd_s4_csr;
    logic trap_cpu, exec_mret, hold_lsu_req, trs_valid;
    csr_addr_t csr_addr;
    trap_cause_t trap_cause;

    // Expectations for the instruction in flight
    xlen_t pc_model, exp_wdata, exp_target, exp_next_pc;
    reg_addr_t exp_rd;
    trap_cause_t exp_cause;
    csr_addr_t exp_csr_addr;
    logic [3:0] exp_csr_uop;
    logic exp_cf, exp_trap, exp_lsu, exp_load, exp_err, exp_fast;
    int exp_nwr, exp_csr, exp_mret;     // exp_nwr of -1 means one or more

    // Handshake model state
    logic rsp_seen, ack_seen;           // Memory response or cf_ack taken at an earlier edge
    logic exp_cf_req, exp_dmem_ack, exp_busy;

    int n_wr, n_csr, n_mret, n_cf, n_cyc;
    int mism_cnt, fail_cnt, cycles;
    logic [31:0] rnd_state;

    frv_writeback u_frv_writeback (.*);

    always #20 g_clk = ~g_clk;

    function automatic logic [31:0] rand32();
        rnd_state = lcg_next(rnd_state);
        return rnd_state;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
            mism_cnt++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("ERROR t=%0t %s", $time, what);
            fail_cnt++;
        end
    endtask

    // --------------------------------------------------
    // Comparing process, samples at the rising edge

    always @(posedge g_clk) begin
        if (g_resetn && s4_valid) begin
            // Request pending until acked, memory wait until the response
            exp_dmem_ack = exp_lsu && !rsp_seen;
            exp_cf_req = exp_cf && !ack_seen && (!exp_lsu || rsp_seen || dmem_recv);
            exp_busy = exp_cf_req || (exp_dmem_ack && !dmem_recv);
            check_val("cf_req", 32'(cf_req), 32'(exp_cf_req));
            check_val("dmem_ack", 32'(dmem_ack), 32'(exp_dmem_ack));
            check_val("hold_lsu_req", 32'(hold_lsu_req), 32'(exp_cf_req || exp_dmem_ack));
            check_val("s4_busy", 32'(s4_busy), 32'(exp_busy));
            check_val("trs_valid", 32'(trs_valid), 32'(!exp_busy && s4_size != '0));
            check_val("fwd_s4_load", 32'(fwd_s4_load), 32'(exp_load));
            check_val("fwd_s4_csr", 32'(fwd_s4_csr), 32'(exp_csr != 0));
            if (exp_dmem_ack && dmem_recv) rsp_seen = 1'b1;
            if (exp_cf_req && cf_ack) ack_seen = 1'b1;
            if (gpr_wen) begin
                n_wr++;
                check_true(exp_nwr != 0, "register write from an instruction without rd");
                check_val("gpr_rd", 32'(gpr_rd), 32'(exp_rd));
                check_val("gpr_wdata", gpr_wdata, exp_wdata);
                check_val("fwd_s4_rd", 32'(fwd_s4_rd), 32'(exp_rd));
                check_val("fwd_s4_wdata", fwd_s4_wdata, exp_wdata);
            end
            if (cf_req) begin
                n_cf++;
                check_true(exp_cf, "control-flow request from an instruction that needs none");
                check_val("cf_target", cf_target, exp_target);
                check_val("trap_cpu", 32'(trap_cpu), 32'(exp_trap));
                if (exp_trap) begin
                    check_val("trap_cause", 32'(trap_cause), 32'(exp_cause));
                    check_val("trap_pc", trap_pc, pc_model);
                end
            end
            if (csr_en) begin
                n_csr++;
                check_val("csr_wr", 32'(csr_wr), 32'(exp_csr_uop[CSR_WRITE]));
                check_val("csr_wr_set", 32'(csr_wr_set), 32'(exp_csr_uop[CSR_SET]));
                check_val("csr_wr_clr", 32'(csr_wr_clr), 32'(exp_csr_uop[CSR_CLEAR]));
                check_val("csr_addr", 32'(csr_addr), 32'(exp_csr_addr));
                check_val("csr_wdata", csr_wdata, s4_opr_a);
            end
            if (exec_mret) n_mret++;
            if (!s4_busy) begin                     // Retire
                check_val("trs_pc", trs_pc, pc_model);
                check_val("trs_instr", trs_instr, s4_instr);
                if (exp_nwr >= 0) check_val("write count", n_wr, exp_nwr);
                else check_true(n_wr > 0, "jump retired without its link write");
                check_val("csr_en count", n_csr, exp_csr);
                check_val("exec_mret count", n_mret, exp_mret);
                if (exp_cf) check_true(n_cf > 0, "no control-flow request was raised");
                if (exp_fast) check_true(n_cyc == 0, "instruction stalled without need");
                if (exp_lsu && !exp_err)
                    check_true(dmem_recv, "memory op retired before its response");
                n_wr = 0;
                n_csr = 0;
                n_mret = 0;
                n_cf = 0;
                n_cyc = 0;
                rsp_seen = 1'b0;
                ack_seen = 1'b0;
            end else begin
                n_cyc++;
            end
        end
    end

    // Run limit
    always @(posedge g_clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("Run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // --------------------------------------------------
    // Stimulus, all changes on the falling edge

    task automatic present(input fu_t fu, input uop_t op, input xlen_t a, input xlen_t b);
        logic [31:0] rnd;
        s4_valid = 1'b1;
        s4_fu = fu;
        s4_uop = op;
        s4_opr_a = a;
        s4_opr_b = b;
        rnd = rand32() % 8;
        s4_size = (rnd == 0) ? 2'd0 : (rnd < 3) ? 2'd1 : 2'd2;  // Mostly 32-bit, few bubbles
        s4_rd = reg_addr_t'(rand32() % 32);
        s4_instr = rand32();
        exp_rd = s4_rd;
        exp_nwr = 0;
        exp_cf = 1'b0;
        exp_trap = 1'b0;
        exp_lsu = 1'b0;
        exp_load = 1'b0;
        exp_err = 1'b0;
        exp_fast = 1'b1;
        exp_csr = 0;
        exp_mret = 0;
        exp_next_pc = pc_model + 32'(s4_size) * 32'd2;
    endtask

    // Hold the instruction, answer handshakes after random delays
    task automatic run_instr();
        int cyc;
        int mem_dly;
        int ack_dly;
        logic done;
        mem_dly = int'(rand32() % 4);
        ack_dly = int'(rand32() % 4);
        cyc = 0;
        done = 1'b0;
        while (!done) begin
            dmem_recv = exp_lsu && (cyc >= mem_dly);
            cf_ack = (cyc >= ack_dly);
            @(posedge g_clk);
            done = s4_valid && !s4_busy;
            @(negedge g_clk);
            cyc++;
        end
        dmem_recv = 1'b0;
        cf_ack = 1'b0;
        dmem_error = 1'b0;
        s4_valid = 1'b0;
        pc_model = exp_next_pc;
        check_val("pc after retire", trs_pc, pc_model);
    endtask

    task automatic do_exec(input int pos);
        present(fu_onehot(pos), uop_t'(rand32() % 32), rand32(), rand32());
        exp_nwr = 1;
        exp_wdata = s4_opr_a;
        run_instr();
    endtask

    task automatic do_load(input logic err);
        logic [1:0] size;
        logic [1:0] addr;
        logic sgn;
        logic [3:0] strb;
        size = 2'(rand32() % 3 + 1);
        sgn = rand32() % 2 == 1;
        addr = (size == LSU_BYTE) ? 2'(rand32() % 4) :
               (size == LSU_HALF) ? {1'(rand32() % 2), 1'b0} : 2'd0;
        strb = (size == LSU_BYTE) ? 4'b0001 << addr :
               (size == LSU_HALF) ? 4'b0011 << addr : 4'b1111;
        present(fu_onehot(P_FU_LSU), {2'b01, size, sgn}, {28'h0, strb},
                {rand32() & 32'hffff_fffc} | 32'(addr));
        dmem_rdata = rand32();
        dmem_error = err;
        exp_lsu = 1'b1;
        exp_load = 1'b1;
        exp_fast = 1'b0;
        exp_err = err;
        if (err) begin
            exp_cf = 1'b1;
            exp_trap = 1'b1;
            exp_cause = TRAP_LDACCESS;
            exp_target = csr_mtvec;
            exp_next_pc = csr_mtvec;
        end else begin
            exp_nwr = 1;
            exp_wdata = ref_load(size, sgn, addr, dmem_rdata);
        end
        run_instr();
    endtask

    task automatic do_store(input logic err);
        present(fu_onehot(P_FU_LSU), 5'b10110, 32'h0000_000f, rand32() & 32'hffff_fffc);
        dmem_error = err;
        exp_lsu = 1'b1;
        exp_fast = 1'b0;
        exp_err = err;
        if (err) begin
            exp_cf = 1'b1;
            exp_trap = 1'b1;
            exp_cause = TRAP_STACCESS;
            exp_target = csr_mtvec;
            exp_next_pc = csr_mtvec;
        end
        run_instr();
    endtask

    task automatic do_cfu(input uop_t op);
        xlen_t seq;
        present(fu_onehot(P_FU_CFU), op, rand32() & 32'hffff_fffe, rand32());
        seq = exp_next_pc;
        exp_target = ref_cf_target(op, s4_opr_a, seq, csr_mepc, csr_mtvec);
        exp_next_pc = exp_target;
        exp_cf = ref_cf_need(op);
        exp_fast = !exp_cf;
        exp_trap = (op == CFU_ECALL) || (op == CFU_EBREAK);
        exp_cause = ref_trap_cause(op);
        exp_mret = (op == CFU_MRET) ? 1 : 0;
        if (ref_link(op)) begin
            exp_wdata = seq;                        // Return address
            exp_nwr = exp_cf ? -1 : 1;
        end
        run_instr();
    endtask

    task automatic do_csr();
        present(fu_onehot(P_FU_CSR), uop_t'(rand32() % 16), rand32(), rand32());
        csr_rdata = rand32();
        exp_csr = 1;
        exp_csr_uop = s4_uop[3:0];
        exp_csr_addr = s4_opr_b[11:0];
        if (s4_uop[CSR_READ]) begin
            exp_nwr = 1;
            exp_wdata = csr_rdata;
        end
        run_instr();
    endtask

    initial begin
        g_clk = 1'b0;
        g_resetn = 1'b0;
        s4_valid = 1'b0;
        s4_trap = 1'b0;
        s4_rd = '0;
        s4_opr_a = '0;
        s4_opr_b = '0;
        s4_uop = '0;
        s4_fu = '0;
        s4_size = '0;
        s4_instr = '0;
        cf_ack = 1'b0;
        dmem_recv = 1'b0;
        dmem_rdata = '0;
        dmem_error = 1'b0;
        csr_rdata = '0;
        csr_mepc = 32'h8000_2000;
        csr_mtvec = 32'h8000_0100;
        rnd_state = 32'ha245fc6c;
        pc_model = PC_RESET;
        {n_wr, n_csr, n_mret, n_cf, n_cyc} = '0;
        rsp_seen = 1'b0;
        ack_seen = 1'b0;
        mism_cnt = 0;
        fail_cnt = 0;
        cycles = 0;
        repeat (4) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;

        for (int i = 0; i < 6; i++) do_exec(i % 2 == 0 ? P_FU_ALU : P_FU_MUL);
        for (int i = 0; i < 10; i++) do_load(1'b0);
        do_load(1'b1);
        do_store(1'b0);
        do_store(1'b1);
        do_cfu(CFU_PT_W);
        do_cfu(CFU_PNT_W);
        do_cfu(CFU_JALR);
        do_cfu(CFU_JALI);
        do_cfu(CFU_LINK);
        do_cfu(CFU_PT_C);
        do_cfu(CFU_PNT_C);
        do_cfu(CFU_ECALL);
        do_cfu(CFU_EBREAK);
        do_cfu(CFU_MRET);
        for (int i = 0; i < 4; i++) do_csr();

        repeat (2) @(negedge g_clk);
        $display("errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
        if (mism_cnt == 0 && fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+verification
source/wb_pkg.sv
source/wb_ctrl.sv
source/wb_cf_resolve.sv
source/wb_load_align.sv
source/wb_gpr_select.sv
source/frv_writeback.sv
verification/tb_writeback.sv

/* Makefile */
TOP = tb_writeback
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f files.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
